/* design/rackctl_pkg.sv */
`default_nettype none

package rackctl_pkg;

    // byte address width of the bus window, only the low nibble is decoded
    localparam int WB_ADR_BITS = 10;

    localparam logic [3:0] CONTROL_ADDR  = 4'h0;
    localparam logic [3:0] FWUPDATE_ADDR = 4'h4;
    localparam logic [3:0] RUNCMD_ADDR   = 4'h8;
    localparam logic [3:0] TRIG_ADDR     = 4'hC;

    localparam int RUNCMD_BITS = 2;
    localparam int TRIG_BITS   = 15;

    // control register layout
    localparam int FIFO_RESET_BIT    = 0;
    localparam int FW_EMPTY_BIT      = 1;
    localparam int RUNCMD_IDLE_BIT   = 2;
    localparam int TRIG_IDLE_BIT     = 3;
    localparam int FW_OVERFLOW_BIT   = 4;
    localparam int MARK_LSB          = 8;
    localparam int EVENT_RESET_BIT   = 16;
    localparam int DISABLE_RXCLK_LSB = 24;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [WB_ADR_BITS-1:0] adr;
        logic [3:0]             sel;
        logic [31:0]            dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic        push;
        logic [31:0] word;
        logic        fifo_reset;
        logic [1:0]  mark_set;
    } fw_ctrl_t;

    typedef struct packed {
        logic                   runcmd_we;
        logic                   trig_we;
        logic [RUNCMD_BITS-1:0] runcmd_data;
        logic [TRIG_BITS-1:0]   trig_data;
    } cmd_wr_t;

    typedef struct packed {
        logic       empty;
        logic       overflow;
        logic [1:0] mark;
    } fw_status_t;

    typedef struct packed {
        logic runcmd_valid;
        logic trig_valid;
    } cmd_status_t;

    typedef struct packed {
        logic       tvalid;
        logic [7:0] tdata;
    } byte_stream_t;

    typedef struct packed {
        logic                   tvalid;
        logic [RUNCMD_BITS-1:0] tdata;
    } runcmd_stream_t;

    typedef struct packed {
        logic                 tvalid;
        logic [TRIG_BITS-1:0] tdata;
    } trig_stream_t;

endpackage

`default_nettype wire

/* design/wb_reg_front.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_reg_front
    import rackctl_pkg::*;
(
    input  wire logic        sysclk_i,
    input  wire logic        reset_i,
    input  wire wb_req_t     wb_i,
    output wb_rsp_t          wb_o,
    output fw_ctrl_t         fw_ctrl_o,
    output cmd_wr_t          cmd_wr_o,
    input  wire fw_status_t  fw_status_i,
    input  wire cmd_status_t cmd_status_i,
    output logic             event_reset_o,
    output logic [7:0]       disable_rxclk_o
);

    logic        ack_q;
    logic        ack;
    logic        wr_cycle;
    logic [3:0]  reg_sel;
    logic        ctrl_wr;
    logic        fifo_reset_q;
    logic        event_reset_q;
    logic [7:0]  disable_rxclk_q;
    logic [31:0] readback;

    // one ack per request, ack is dropped as soon as the master lets go of cyc
    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_i.cyc && wb_i.stb && !ack_q;
        end
    end

    assign ack = ack_q && wb_i.cyc;

    // writes commit at the edge closing the ack cycle
    assign wr_cycle = ack && wb_i.stb && wb_i.we;
    assign reg_sel  = wb_i.adr[3:0];
    assign ctrl_wr  = wr_cycle && (reg_sel == CONTROL_ADDR);

    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            fifo_reset_q    <= 1'b0;
            event_reset_q   <= 1'b0;
            disable_rxclk_q <= 8'hFF;
        end else if (ctrl_wr) begin
            if (wb_i.sel[0]) begin
                fifo_reset_q <= wb_i.dat[FIFO_RESET_BIT];
            end
            if (wb_i.sel[2]) begin
                event_reset_q <= wb_i.dat[EVENT_RESET_BIT];
            end
            if (wb_i.sel[3]) begin
                disable_rxclk_q <= wb_i.dat[DISABLE_RXCLK_LSB +: 8];
            end
        end
    end

    always_comb begin
        fw_ctrl_o.push       = wr_cycle && (reg_sel == FWUPDATE_ADDR);
        fw_ctrl_o.word       = wb_i.dat;
        fw_ctrl_o.fifo_reset = fifo_reset_q;
        // marks only set here, clearing happens downstream on the acknowledge
        fw_ctrl_o.mark_set   = wb_i.dat[MARK_LSB +: 2] & {2{ctrl_wr && wb_i.sel[1]}};
    end

    always_comb begin
        cmd_wr_o.runcmd_we   = wr_cycle && (reg_sel == RUNCMD_ADDR) && wb_i.sel[0];
        cmd_wr_o.trig_we     = wr_cycle && (reg_sel == TRIG_ADDR) && (&wb_i.sel[1:0]);
        cmd_wr_o.runcmd_data = wb_i.dat[RUNCMD_BITS-1:0];
        cmd_wr_o.trig_data   = wb_i.dat[TRIG_BITS-1:0];
    end

    // every address reads back the control word
    always_comb begin
        readback                              = '0;
        readback[FIFO_RESET_BIT]              = fifo_reset_q;
        readback[FW_EMPTY_BIT]                = fw_status_i.empty;
        readback[RUNCMD_IDLE_BIT]             = !cmd_status_i.runcmd_valid;
        readback[TRIG_IDLE_BIT]               = !cmd_status_i.trig_valid;
        readback[FW_OVERFLOW_BIT]             = fw_status_i.overflow;
        readback[MARK_LSB +: 2]               = fw_status_i.mark;
        readback[EVENT_RESET_BIT]             = event_reset_q;
        readback[DISABLE_RXCLK_LSB +: 8]      = disable_rxclk_q;
    end

    always_comb begin
        wb_o.ack = ack;
        wb_o.dat = readback;
    end

    assign event_reset_o   = event_reset_q;
    assign disable_rxclk_o = disable_rxclk_q;

    // an ack only ever answers a request that the master still holds on the bus
    a_ack_on_request : assert property (@(posedge sysclk_i) disable iff (reset_i)
        wb_o.ack |-> wb_i.cyc && wb_i.stb);

endmodule

`default_nettype wire

/* design/fw_stream.sv */
`timescale 1ns/1ps
`default_nettype none

module fw_stream
    import rackctl_pkg::*;
#(
    parameter int FW_FIFO_DEPTH = 16
) (
    input  wire logic     sysclk_i,
    input  wire logic     reset_i,
    input  wire fw_ctrl_t fw_ctrl_i,
    output byte_stream_t  fw_o,
    input  wire logic     fw_tready_i,
    output logic [1:0]    fw_mark_o,
    input  wire logic     fw_marked_i,
    output fw_status_t    fw_status_o
);

    localparam int PTR_BITS = $clog2(FW_FIFO_DEPTH);

    logic [31:0]       mem [FW_FIFO_DEPTH];
    logic [PTR_BITS:0] wr_ptr_q;
    logic [PTR_BITS:0] rd_ptr_q;
    logic              flush;
    logic              fifo_empty;
    logic              fifo_full;
    logic              push_ok;
    logic              byte_take;
    logic              last_byte;
    logic              load;
    logic [31:0]       word_q;
    logic [1:0]        byte_idx_q;
    logic              busy_q;
    logic              overflow_q;
    logic [1:0]        mark_q;

    assign flush      = fw_ctrl_i.fifo_reset;
    assign fifo_empty = (wr_ptr_q == rd_ptr_q);
    // pointers carry one extra wrap bit so full and empty can be told apart
    assign fifo_full  = (wr_ptr_q[PTR_BITS] != rd_ptr_q[PTR_BITS]) &&
                        (wr_ptr_q[PTR_BITS-1:0] == rd_ptr_q[PTR_BITS-1:0]);
    assign push_ok    = fw_ctrl_i.push && !fifo_full && !flush;
    assign byte_take  = busy_q && fw_tready_i;
    assign last_byte  = (byte_idx_q == 2'd3);
    // refill on the same edge that hands out the last byte, so the stream keeps flowing
    assign load       = !fifo_empty && !flush && (!busy_q || (byte_take && last_byte));

    always_ff @(posedge sysclk_i) begin
        if (reset_i || flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (load) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (push_ok) begin
            mem[wr_ptr_q[PTR_BITS-1:0]] <= fw_ctrl_i.word;
        end
    end

    // serializer walks the held word out low byte first
    always_ff @(posedge sysclk_i) begin
        if (reset_i || flush) begin
            busy_q     <= 1'b0;
            byte_idx_q <= 2'd0;
        end else if (load) begin
            busy_q     <= 1'b1;
            byte_idx_q <= 2'd0;
        end else if (byte_take) begin
            busy_q     <= !last_byte;
            byte_idx_q <= byte_idx_q + 2'd1;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (load) begin
            word_q <= mem[rd_ptr_q[PTR_BITS-1:0]];
        end else if (byte_take) begin
            word_q <= {8'h00, word_q[31:8]};
        end
    end

    // sticky until software pulses the FIFO reset
    always_ff @(posedge sysclk_i) begin
        if (reset_i || flush) begin
            overflow_q <= 1'b0;
        end else if (fw_ctrl_i.push && fifo_full) begin
            overflow_q <= 1'b1;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            mark_q <= 2'b00;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (fw_ctrl_i.mark_set[i]) begin
                    mark_q[i] <= 1'b1;
                end else if (fw_marked_i) begin
                    mark_q[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        fw_o.tvalid          = busy_q;
        fw_o.tdata           = word_q[7:0];
        fw_status_o.empty    = fifo_empty && !busy_q;
        fw_status_o.overflow = overflow_q;
        fw_status_o.mark     = mark_q;
    end

    assign fw_mark_o = mark_q;

    a_fw_hold : assert property (@(posedge sysclk_i) disable iff (reset_i)
        fw_o.tvalid && !fw_tready_i |=> $stable(fw_o.tdata));

endmodule

`default_nettype wire

/* design/cmd_holding.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_holding
    import rackctl_pkg::*;
(
    input  wire logic      sysclk_i,
    input  wire logic      reset_i,
    input  wire cmd_wr_t   cmd_wr_i,
    output runcmd_stream_t runcmd_o,
    input  wire logic      runcmd_tready_i,
    output trig_stream_t   trig_o,
    input  wire logic      trig_tready_i,
    output cmd_status_t    cmd_status_o
);

    logic                   runcmd_valid_q;
    logic [RUNCMD_BITS-1:0] runcmd_data_q;
    logic                   trig_valid_q;
    logic [TRIG_BITS-1:0]   trig_data_q;

    // a write while the old value is still pending overwrites it and keeps valid high
    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            runcmd_valid_q <= 1'b0;
            runcmd_data_q  <= '0;
        end else if (cmd_wr_i.runcmd_we) begin
            runcmd_valid_q <= 1'b1;
            runcmd_data_q  <= cmd_wr_i.runcmd_data;
        end else if (runcmd_tready_i) begin
            runcmd_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            trig_valid_q <= 1'b0;
            trig_data_q  <= '0;
        end else if (cmd_wr_i.trig_we) begin
            trig_valid_q <= 1'b1;
            trig_data_q  <= cmd_wr_i.trig_data;
        end else if (trig_tready_i) begin
            trig_valid_q <= 1'b0;
        end
    end

    always_comb begin
        runcmd_o.tvalid           = runcmd_valid_q;
        runcmd_o.tdata            = runcmd_data_q;
        trig_o.tvalid             = trig_valid_q;
        trig_o.tdata              = trig_data_q;
        cmd_status_o.runcmd_valid = runcmd_valid_q;
        cmd_status_o.trig_valid   = trig_valid_q;
    end

    // a stalled item keeps its data and its valid unless software overwrites it
    a_runcmd_hold : assert property (@(posedge sysclk_i) disable iff (reset_i)
        runcmd_o.tvalid && !runcmd_tready_i && !cmd_wr_i.runcmd_we
        |=> runcmd_o.tvalid && $stable(runcmd_o.tdata));

    a_trig_hold : assert property (@(posedge sysclk_i) disable iff (reset_i)
        trig_o.tvalid && !trig_tready_i && !cmd_wr_i.trig_we
        |=> trig_o.tvalid && $stable(trig_o.tdata));

endmodule

`default_nettype wire

/* design/rackctl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rackctl_top
    import rackctl_pkg::*;
#(
    parameter int FW_FIFO_DEPTH = 16
) (
    input  wire logic      sysclk_i,
    input  wire logic      reset_i,
    input  wire wb_req_t   wb_i,
    output wb_rsp_t        wb_o,
    output byte_stream_t   fw_o,
    input  wire logic      fw_tready_i,
    output logic [1:0]     fw_mark_o,
    input  wire logic      fw_marked_i,
    output runcmd_stream_t runcmd_o,
    input  wire logic      runcmd_tready_i,
    output trig_stream_t   trig_o,
    input  wire logic      trig_tready_i,
    output logic           event_reset_o,
    output logic [7:0]     disable_rxclk_o
);

    fw_ctrl_t    fw_ctrl;
    cmd_wr_t     cmd_wr;
    fw_status_t  fw_status;
    cmd_status_t cmd_status;

    // register front end, owns the bus and the control word
    wb_reg_front u_wb_reg_front (
        .sysclk_i        (sysclk_i),
        .reset_i         (reset_i),
        .wb_i            (wb_i),
        .wb_o            (wb_o),
        .fw_ctrl_o       (fw_ctrl),
        .cmd_wr_o        (cmd_wr),
        .fw_status_i     (fw_status),
        .cmd_status_i    (cmd_status),
        .event_reset_o   (event_reset_o),
        .disable_rxclk_o (disable_rxclk_o)
    );

    fw_stream #(
        .FW_FIFO_DEPTH (FW_FIFO_DEPTH)
    ) u_fw_stream (
        .sysclk_i    (sysclk_i),
        .reset_i     (reset_i),
        .fw_ctrl_i   (fw_ctrl),
        .fw_o        (fw_o),
        .fw_tready_i (fw_tready_i),
        .fw_mark_o   (fw_mark_o),
        .fw_marked_i (fw_marked_i),
        .fw_status_o (fw_status)
    );

    cmd_holding u_cmd_holding (
        .sysclk_i        (sysclk_i),
        .reset_i         (reset_i),
        .cmd_wr_i        (cmd_wr),
        .runcmd_o        (runcmd_o),
        .runcmd_tready_i (runcmd_tready_i),
        .trig_o          (trig_o),
        .trig_tready_i   (trig_tready_i),
        .cmd_status_o    (cmd_status)
    );

endmodule

`default_nettype wire

/* testbench/rackctl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rackctl_tb
    import rackctl_pkg::*;
();

    localparam int FW_FIFO_DEPTH   = 16;
    localparam int RANDOM_ACCESSES = 360;
    // about four cycles per access, with ten times that as room for the drains
    localparam int CYCLE_LIMIT     = (RANDOM_ACCESSES + 140) * 40;
    localparam int ACK_WAIT        = 8;

    logic           sysclk;
    logic           reset;
    wb_req_t        wb;
    wb_rsp_t        wb_rsp;
    byte_stream_t   fw;
    logic           fw_tready;
    logic [1:0]     fw_mark;
    logic           fw_marked;
    runcmd_stream_t runcmd;
    logic           runcmd_tready;
    trig_stream_t   trig;
    logic           trig_tready;
    logic           event_reset;
    logic [7:0]     disable_rxclk;

    // reference model state
    logic [31:0]            ctrl_m;
    logic [1:0]             mark_m;
    logic                   overflow_m;
    logic [7:0]             fw_queue[$];
    logic [RUNCMD_BITS-1:0] runcmd_m;
    logic                   runcmd_valid_m;
    logic [TRIG_BITS-1:0]   trig_m;
    logic                   trig_valid_m;

    // model status at the last falling edge, taken before that edge's handshakes
    logic                   snap_empty;
    logic [1:0]             snap_mark;
    logic                   snap_runcmd_valid;
    logic                   snap_trig_valid;

    logic [31:0] bus_rng;
    logic [31:0] ready_rng;
    int          fw_ready_mode;
    int          cycle_count;
    int          mismatches;
    int          other_errors;

    rackctl_top #(
        .FW_FIFO_DEPTH (FW_FIFO_DEPTH)
    ) DUT (
        .sysclk_i        (sysclk),
        .reset_i         (reset),
        .wb_i            (wb),
        .wb_o            (wb_rsp),
        .fw_o            (fw),
        .fw_tready_i     (fw_tready),
        .fw_mark_o       (fw_mark),
        .fw_marked_i     (fw_marked),
        .runcmd_o        (runcmd),
        .runcmd_tready_i (runcmd_tready),
        .trig_o          (trig),
        .trig_tready_i   (trig_tready),
        .event_reset_o   (event_reset),
        .disable_rxclk_o (disable_rxclk)
    );

    initial begin
        sysclk = 1'b0;
        forever begin
            #10 sysclk = ~sysclk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_word(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_mark(input logic [1:0] act, input logic [1:0] exp);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: fw_mark_o got %b expected %b", $time, act, exp);
        end
    endtask

    task automatic check_byte(input byte_stream_t act, input byte_stream_t exp);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: fw_o got %b/%h expected %b/%h",
                     $time, act.tvalid, act.tdata, exp.tvalid, exp.tdata);
        end
    endtask

    task automatic check_runcmd(input runcmd_stream_t act, input runcmd_stream_t exp);
        if (act.tvalid !== exp.tvalid || (exp.tvalid && act.tdata !== exp.tdata)) begin
            mismatches++;
            $display("Mismatch at %0t: runcmd_o got %b/%h expected %b/%h",
                     $time, act.tvalid, act.tdata, exp.tvalid, exp.tdata);
        end
    endtask

    task automatic check_trig(input trig_stream_t act, input trig_stream_t exp);
        if (act.tvalid !== exp.tvalid || (exp.tvalid && act.tdata !== exp.tdata)) begin
            mismatches++;
            $display("Mismatch at %0t: trig_o got %b/%h expected %b/%h",
                     $time, act.tvalid, act.tdata, exp.tvalid, exp.tdata);
        end
    endtask

    function automatic logic [31:0] expected_readback();
        logic [31:0] w;
        w                  = ctrl_m;
        w[FW_EMPTY_BIT]    = snap_empty;
        w[RUNCMD_IDLE_BIT] = !snap_runcmd_valid;
        w[TRIG_IDLE_BIT]   = !snap_trig_valid;
        w[FW_OVERFLOW_BIT] = overflow_m;
        w[MARK_LSB +: 2]   = snap_mark;
        return w;
    endfunction

    // model side of a write, applied at the edge that closes its ack cycle
    task automatic apply_write(input logic [3:0] adr, input logic [3:0] sel,
                               input logic [31:0] dat);
        case (adr)
            CONTROL_ADDR: begin
                if (sel[0]) begin
                    ctrl_m[FIFO_RESET_BIT] = dat[FIFO_RESET_BIT];
                    if (dat[FIFO_RESET_BIT]) begin
                        fw_queue.delete();
                        overflow_m = 1'b0;
                    end
                end
                if (sel[1]) begin
                    mark_m = mark_m | dat[MARK_LSB +: 2];
                end
                if (sel[2]) begin
                    ctrl_m[EVENT_RESET_BIT] = dat[EVENT_RESET_BIT];
                end
                if (sel[3]) begin
                    ctrl_m[DISABLE_RXCLK_LSB +: 8] = dat[DISABLE_RXCLK_LSB +: 8];
                end
            end
            FWUPDATE_ADDR: begin
                // one word sits in the serializer on top of the FIFO depth
                if (ctrl_m[FIFO_RESET_BIT]) begin
                    overflow_m = 1'b0;
                end else if ((fw_queue.size() + 3) / 4 >= FW_FIFO_DEPTH + 1) begin
                    overflow_m = 1'b1;
                end else begin
                    for (int i = 0; i < 4; i++) begin
                        fw_queue.push_back(dat[8*i +: 8]);
                    end
                end
            end
            RUNCMD_ADDR: begin
                if (sel[0]) begin
                    runcmd_m       = dat[RUNCMD_BITS-1:0];
                    runcmd_valid_m = 1'b1;
                end
            end
            default: begin
                if (&sel[1:0]) begin
                    trig_m       = dat[TRIG_BITS-1:0];
                    trig_valid_m = 1'b1;
                end
            end
        endcase
    endtask

    task automatic bus_access(input logic we, input logic [3:0] adr, input logic [3:0] sel,
                              input logic [31:0] dat);
        wb_req_t     req;
        logic        acked;
        logic [31:0] rdat;
        int          waited;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = WB_ADR_BITS'(adr);
        req.sel = sel;
        req.dat = dat;
        @(posedge sysclk);
        wb <= req;
        waited = 0;
        acked  = 1'b0;
        while (!acked && waited < ACK_WAIT) begin
            @(negedge sysclk);
            acked = (wb_rsp.ack === 1'b1);
            waited++;
        end
        rdat = wb_rsp.dat;
        @(posedge sysclk);
        wb <= '0;
        if (!acked) begin
            other_errors++;
            $display("no ack within %0d cycles for the access to offset 0x%h", ACK_WAIT, adr);
        end else begin
            // the first falling edge lies in the request cycle, the ack is due one cycle later
            if (waited != 2) begin
                other_errors++;
                $display("ack for the access to offset 0x%h came %0d cycles late instead of 1",
                         adr, waited - 1);
            end
            check_word("wb_o.dat", rdat, expected_readback());
            if (we) begin
                apply_write(adr, sel, dat);
            end
        end
    endtask

    task automatic wait_fw_drained();
        while (fw_queue.size() != 0) begin
            @(negedge sysclk);
        end
        // the last byte leaves on the edge after the model has taken it
        repeat (3) @(negedge sysclk);
    endtask

    // ready and acknowledge patterns, each cycle from their own generator
    always @(posedge sysclk) begin
        ready_rng = xorshift(ready_rng);
        case (fw_ready_mode)
            1: fw_tready <= 1'b0;
            2: fw_tready <= 1'b1;
            default: fw_tready <= ready_rng[0];
        endcase
        runcmd_tready <= ready_rng[9] & ready_rng[10];
        trig_tready   <= ready_rng[13] & ready_rng[14];
        fw_marked     <= (ready_rng[20:17] == 4'd0);
    end

    // outputs are stable at the falling edge, handshakes complete at the next rise
    always @(negedge sysclk) begin
        if (!reset) begin
            snap_empty        = (fw_queue.size() == 0);
            snap_mark         = mark_m;
            snap_runcmd_valid = runcmd_valid_m;
            snap_trig_valid   = trig_valid_m;
            check_mark(fw_mark, mark_m);
            check_word("event_reset_o", {31'b0, event_reset}, {31'b0, ctrl_m[EVENT_RESET_BIT]});
            check_word("disable_rxclk_o", {24'b0, disable_rxclk},
                       {24'b0, ctrl_m[DISABLE_RXCLK_LSB +: 8]});
            check_runcmd(runcmd, {runcmd_valid_m, runcmd_m});
            check_trig(trig, {trig_valid_m, trig_m});
            if (fw.tvalid === 1'b1 && fw_tready) begin
                if (fw_queue.size() == 0) begin
                    other_errors++;
                    $display("firmware byte %h accepted at %0t with nothing left to send",
                             fw.tdata, $time);
                end else begin
                    check_byte(fw, {1'b1, fw_queue.pop_front()});
                end
            end
            if (runcmd_valid_m && runcmd_tready) begin
                runcmd_valid_m = 1'b0;
            end
            if (trig_valid_m && trig_tready) begin
                trig_valid_m = 1'b0;
            end
            // a set strobe on the same edge is applied afterwards and wins
            if (fw_marked) begin
                mark_m = 2'b00;
            end
        end
    end

    always @(posedge sysclk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        reset             = 1'b1;
        wb                = '0;
        fw_tready         = 1'b0;
        fw_marked         = 1'b0;
        runcmd_tready     = 1'b0;
        trig_tready       = 1'b0;
        ctrl_m            = 32'hFF00_0000;
        mark_m            = 2'b00;
        overflow_m        = 1'b0;
        runcmd_m          = '0;
        runcmd_valid_m    = 1'b0;
        trig_m            = '0;
        trig_valid_m      = 1'b0;
        snap_empty        = 1'b1;
        snap_mark         = 2'b00;
        snap_runcmd_valid = 1'b0;
        snap_trig_valid   = 1'b0;
        bus_rng           = 32'd34;
        ready_rng         = 32'd34 ^ 32'h9E37_79B9;
        fw_ready_mode     = 0;
        cycle_count       = 0;
        mismatches        = 0;
        other_errors      = 0;
        repeat (10) @(posedge sysclk);
        reset <= 1'b0;

        bus_access(1'b0, CONTROL_ADDR, 4'hF, 32'h0);

        // mixed traffic, the FIFO reset bit stays clear so no byte is cut off mid-stream
        repeat (RANDOM_ACCESSES) begin
            bus_rng = xorshift(bus_rng);
            r       = bus_rng;
            bus_rng = xorshift(bus_rng);
            d       = bus_rng;
            case (r[2:0])
                3'd0, 3'd1: bus_access(1'b1, CONTROL_ADDR, r[7:4], d & 32'hFFFF_FFFE);
                3'd2, 3'd3: begin
                    if (fw_queue.size() < 60) begin
                        bus_access(1'b1, FWUPDATE_ADDR, r[7:4], d);
                    end else begin
                        bus_access(1'b0, FWUPDATE_ADDR, r[7:4], d);
                    end
                end
                3'd4: bus_access(1'b1, RUNCMD_ADDR, r[7:4], d);
                3'd5: bus_access(1'b1, TRIG_ADDR, r[7:4], d);
                default: bus_access(1'b0, {r[9:8], 2'b00}, r[7:4], d);
            endcase
        end

        // overflow with the stream stalled, then drain and clear
        @(negedge sysclk);
        fw_ready_mode = 2;
        wait_fw_drained();
        fw_ready_mode = 1;
        repeat (FW_FIFO_DEPTH + 3) begin
            bus_rng = xorshift(bus_rng);
            bus_access(1'b1, FWUPDATE_ADDR, 4'hF, bus_rng);
        end
        bus_access(1'b0, CONTROL_ADDR, 4'hF, 32'h0);
        @(negedge sysclk);
        fw_ready_mode = 2;
        wait_fw_drained();
        bus_access(1'b0, CONTROL_ADDR, 4'hF, 32'h0);
        bus_access(1'b1, CONTROL_ADDR, 4'b0001, 32'h0000_0001);
        bus_access(1'b1, CONTROL_ADDR, 4'b0001, 32'h0000_0000);
        bus_access(1'b0, CONTROL_ADDR, 4'hF, 32'h0);

        bus_access(1'b1, CONTROL_ADDR, 4'b0010, 32'h0000_0300);
        bus_access(1'b0, CONTROL_ADDR, 4'hF, 32'h0);
        repeat (40) @(negedge sysclk);
        bus_access(1'b0, CONTROL_ADDR, 4'hF, 32'h0);

        $display("checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rackctl.f */
design/rackctl_pkg.sv
design/wb_reg_front.sv
design/fw_stream.sv
design/cmd_holding.sv
design/rackctl_top.sv
testbench/rackctl_tb.sv

/* Makefile */
# Verilator build and run for the rackctl testbench

VERILATOR ?= verilator
TOP       ?= rackctl_tb
LINT_TOP  ?= rackctl_top
FILELIST  ?= rackctl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Result: PASSED" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
